//--- compile.f
+incdir+include
hdl/memUnitPkg.sv
hdl/affineAddrGen.sv
hdl/dualPortRam.sv
hdl/memUnit.sv
verification/memUnitTb.sv

//--- Makefile
SIM      = verilator
TOP      = memUnitTb
FILELIST = compile.f
FLAGS    = --binary --timing --assert -j 0
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
PASS_MSG = Simulation completed successfully
SOURCES  = $(filter-out +%,$(shell cat $(FILELIST))) include/memUnit_cfg.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verification/memUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "memUnit_cfg.svh"

module memUnitTb
   import memUnitPkg::*;
;

   localparam int CLK_NS = 8;
   localparam int DONE_LIMIT = 200;
   // longest stream is run pulse plus delay 5 plus 3 x 4 x 4 active cycles plus done
   localparam int STREAM_CYCLES = 2 + 5 + 48 + 1;
   localparam int BUDGET_CYCLES = 6 + 32 * 4 + (2 << `MEM_ADDR_W) + 6 * STREAM_CYCLES + 48 * 2;
   localparam int WATCHDOG_NS = 2 * BUDGET_CYCLES * CLK_NS;

   logic                  clk;
   logic                  rstN;
   logic                  run;
   logic                  valid;
   logic                  we;
   addrT                  addr;
   wordT                  rdata;
   wordT [`N_SOURCES-1:0] flowIn;
   memPortCfgT            cfgA;
   memPortCfgT            cfgB;
   wordT                  outA;
   wordT                  outB;
   logic                  doneA;
   logic                  doneB;

   // reference memory and the expected stream of the running generator
   wordT model [0:(1 << `MEM_ADDR_W)-1];
   addrT schedAddr[$];
   bit   schedEn[$];

   int checks = 0;
   int errors = 0;
   int tick = 0;

   memUnit memUnit_i (
      .clk    (clk),
      .rstN   (rstN),
      .run    (run),
      .valid  (valid),
      .we     (we),
      .addr   (addr),
      .rdata  (rdata),
      .flowIn (flowIn),
      .cfgA   (cfgA),
      .cfgB   (cfgB),
      .outA   (outA),
      .outB   (outB),
      .doneA  (doneA),
      .doneB  (doneB)
   );

   always #(CLK_NS / 2) clk = ~clk;

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests finished");
      $display("checks run: %0d, errors: %0d", checks, errors);
      $display("Simulation failed");
      $finish;
   end

   task automatic matchWord(input string name, input wordT got, input wordT exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic verifyFlag(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic compareOut(input bit onB, input wordT exp);
      if (onB)
         matchWord("outB", outB, exp);
      else
         matchWord("outA", outA, exp);
   endtask

   task automatic expectDone(input bit onB, input logic exp);
      if (onB)
         verifyFlag("doneB", doneB, exp);
      else
         verifyFlag("doneA", doneA, exp);
   endtask

   function automatic addrT flipAddr(input addrT a);
      addrT r;
      r = {<<{a}};
      return r;
   endfunction

   // small loop counts keep each stream short
   function automatic memPortCfgT randomCfg();
      memPortCfgT c;
      c = '0;
      c.per = `PERIOD_W'($urandom_range(4, 1));
      c.duty = `PERIOD_W'($urandom_range(32'(c.per), 1));
      c.iter = addrT'($urandom_range(4, 1));
      c.iter2 = addrT'($urandom_range(3, 1));
      c.delay = `PERIOD_W'($urandom_range(5, 0));
      c.start = addrT'($urandom);
      c.incr = addrT'($urandom);
      c.shift = addrT'($urandom);
      c.shift2 = addrT'($urandom);
      return c;
   endfunction

   task automatic buildSchedule(input memPortCfgT c);
      int outerN;
      int innerN;
      int perN;
      int sum;
      outerN = (c.iter2 == '0) ? 1 : int'(c.iter2);
      innerN = (c.iter == '0) ? 1 : int'(c.iter);
      perN = (c.per == '0) ? 1 : int'(c.per);
      schedAddr.delete();
      schedEn.delete();
      for (int i = 0; i < outerN; i++)
         for (int j = 0; j < innerN; j++)
            for (int k = 0; k < perN; k++)
            begin
               sum = int'(c.start) + i * int'(c.shift2) + j * int'(c.shift)
                     + k * int'(c.incr);
               schedAddr.push_back(addrT'(sum));
               schedEn.push_back(k < int'(c.duty));
            end
   endtask

   task automatic writeByHost(input addrT a, input wordT d);
      @(negedge clk);
      valid = 1'b1;
      we = 1'b1;
      addr = a;
      rdata = d;
      @(negedge clk);
      valid = 1'b0;
      we = 1'b0;
      model[a] = d;
   endtask

   task automatic readByHost(input addrT a);
      @(negedge clk);
      valid = 1'b1;
      we = 1'b0;
      addr = a;
      @(negedge clk);
      valid = 1'b0;
      matchWord("outA", outA, model[a]);
   endtask

   task automatic waitDone(input bit onB);
      int waited;
      waited = 0;
      expectDone(onB, 1'b1);
      while (!(onB ? doneB : doneA) && waited < DONE_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (!(onB ? doneB : doneA))
      begin
         errors++;
         $display("done of port %s never rose after the run", onB ? "B" : "A");
      end
   endtask

   // one run with port A writing flowIn[3] or one port reading
   // done timing is checked in every cycle
   task automatic playStream(input memPortCfgT c, input bit onB, input bit writing,
                             input bit extAddr, input bit pokeRun);
      int   d;
      int   n;
      bit   pending;
      addrT pendAddr;
      addrT a;
      d = int'(c.delay);
      buildSchedule(c);
      n = schedAddr.size();
      pending = 1'b0;
      pendAddr = '0;
      @(negedge clk);
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
      for (int cnt = 0; cnt < d + n; cnt++)
      begin
         expectDone(onB, 1'b0);
         if (pending)
            compareOut(onB, model[pendAddr]);
         pending = 1'b0;
         tick++;
         flowIn[3] = wordT'(tick);
         flowIn[5] = wordT'($urandom);
         // lands while busy and must not restart
         run = pokeRun && (cnt == 1);
         if (cnt >= d)
         begin
            a = schedAddr[cnt - d];
            if (extAddr)
               a = flowIn[5][`MEM_ADDR_W-1:0];
            else if (c.reverse)
               a = flipAddr(a);
            if (schedEn[cnt - d] && writing)
               model[a] = flowIn[3];
            else if (schedEn[cnt - d])
            begin
               pending = 1'b1;
               pendAddr = a;
            end
         end
         @(negedge clk);
      end
      run = 1'b0;
      if (pending)
         compareOut(onB, model[pendAddr]);
      waitDone(onB);
   endtask

   task automatic hostLoadRead();
      addrT used[$];
      addrT a;
      for (int i = 0; i < 32; i++)
      begin
         a = addrT'($urandom);
         writeByHost(a, wordT'($urandom));
         used.push_back(a);
      end
      foreach (used[i])
         readByHost(used[i]);
   endtask

   task automatic streamWrite();
      memPortCfgT c;
      c = randomCfg();
      c.sel = `N_W'(3);
      c.inWr = 1'b1;
      cfgA = c;
      cfgB = '0;
      playStream(c, 1'b0, 1'b1, 1'b0, 1'b0);
      for (int i = 0; i < schedAddr.size(); i++)
         if (schedEn[i])
            readByHost(schedAddr[i]);
   endtask

   task automatic streamRead();
      memPortCfgT c;
      for (int a = 0; a < (1 << `MEM_ADDR_W); a++)
         writeByHost(addrT'(a), wordT'($urandom));
      c = randomCfg();
      cfgA = '0;
      cfgB = c;
      playStream(c, 1'b1, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic reversedRead();
      memPortCfgT c;
      c = randomCfg();
      c.reverse = 1'b1;
      cfgA = '0;
      cfgB = c;
      playStream(c, 1'b1, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic externalAddress();
      memPortCfgT c;
      c = randomCfg();
      cfgA = c;
      cfgB = '0;
      cfgB.ext = 1'b1;
      cfgB.sel = `N_W'(5);
      playStream(c, 1'b0, 1'b0, 1'b1, 1'b0);
   endtask

   task automatic doneAndRerun();
      memPortCfgT c;
      c = randomCfg();
      // zero inner count runs as one
      c.iter = '0;
      c.iter2 = addrT'($urandom_range(3, 2));
      cfgA = c;
      cfgB = '0;
      playStream(c, 1'b0, 1'b0, 1'b0, 1'b1);
      playStream(c, 1'b0, 1'b0, 1'b0, 1'b0);
   endtask

   initial
   begin
      void'($urandom(32'h3075be41));
      clk = 1'b0;
      rstN = 1'b0;
      run = 1'b0;
      valid = 1'b0;
      we = 1'b0;
      addr = '0;
      rdata = '0;
      flowIn = '0;
      cfgA = '0;
      cfgB = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
      verifyFlag("doneA", doneA, 1'b1);
      verifyFlag("doneB", doneB, 1'b1);

      hostLoadRead();
      streamWrite();
      streamRead();
      reversedRead();
      externalAddress();
      doneAndRerun();

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/memUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "memUnit_cfg.svh"

module memUnit
   import memUnitPkg::*;
(
   input  logic                    clk,
   input  logic                    rstN,
   input  logic                    run,

   // host access takes port A while valid
   input  logic                    valid,
   input  logic                    we,
   input  addrT                    addr,
   input  wordT                    rdata,

   input  wordT [`N_SOURCES-1:0]   flowIn,

   input  memPortCfgT              cfgA,
   input  memPortCfgT              cfgB,

   output wordT                    outA,
   output wordT                    outB,
   output logic                    doneA,
   output logic                    doneB
);

   // selected input words
   wordT inA;
   wordT inB;

   addrT genAddrA;
   addrT genAddrB;
   addrT seqAddrA;
   addrT seqAddrB;
   logic memEnA;
   logic memEnB;

   // ram port signals
   addrT addrA;
   addrT addrB;
   logic enA;
   logic enB;
   logic weA;
   logic weB;
   wordT dataA;

   function automatic addrT reverseBits(input addrT a);
      addrT r;
      for (int i = 0; i < `MEM_ADDR_W; i++)
      begin
         r[i] = a[`MEM_ADDR_W-1-i];
      end
      return r;
   endfunction

   assign inA = flowIn[cfgA.sel];
   assign inB = flowIn[cfgB.sel];

   affineAddrGen addrGenA (
      .clk     (clk),
      .rstN    (rstN),
      .run     (run),
      .iter    (cfgA.iter),
      .per     (cfgA.per),
      .duty    (cfgA.duty),
      .start   (cfgA.start),
      .incr    (cfgA.incr),
      .shift   (cfgA.shift),
      .delay   (cfgA.delay),
      .iter2   (cfgA.iter2),
      .shift2  (cfgA.shift2),
      .genAddr (genAddrA),
      .memEn   (memEnA),
      .done    (doneA)
   );

   affineAddrGen addrGenB (
      .clk     (clk),
      .rstN    (rstN),
      .run     (run),
      .iter    (cfgB.iter),
      .per     (cfgB.per),
      .duty    (cfgB.duty),
      .start   (cfgB.start),
      .incr    (cfgB.incr),
      .shift   (cfgB.shift),
      .delay   (cfgB.delay),
      .iter2   (cfgB.iter2),
      .shift2  (cfgB.shift2),
      .genAddr (genAddrB),
      .memEn   (memEnB),
      .done    (doneB)
   );

   assign seqAddrA = cfgA.reverse ? reverseBits(genAddrA) : genAddrA;
   assign seqAddrB = cfgB.reverse ? reverseBits(genAddrB) : genAddrB;

   // host over the other port's word over the pattern
   assign addrA = valid     ? addr :
                  cfgB.ext  ? inB[`MEM_ADDR_W-1:0] :
                              seqAddrA;

   // no host path on B
   assign addrB = cfgA.ext ? inA[`MEM_ADDR_W-1:0] : seqAddrB;

   assign enA = valid | memEnA;
   assign enB = memEnB;

   // an input used as an address is never written
   assign weA = valid ? we : (memEnA & cfgA.inWr & ~cfgA.ext);
   assign weB = memEnB & cfgB.inWr & ~cfgB.ext;

   assign dataA = valid ? rdata : inA;

   dualPortRam ram (
      .clk   (clk),
      .enA   (enA),
      .enB   (enB),
      .weA   (weA),
      .weB   (weB),
      .addrA (addrA),
      .addrB (addrB),
      .dataA (dataA),
      .dataB (inB),
      .qA    (outA),
      .qB    (outB)
   );

endmodule

`default_nettype wire

//--- hdl/dualPortRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "memUnit_cfg.svh"

module dualPortRam
   import memUnitPkg::*;
(
   input  logic clk,
   input  logic enA,
   input  logic enB,
   input  logic weA,
   input  logic weB,
   input  addrT addrA,
   input  addrT addrB,
   input  wordT dataA,
   input  wordT dataB,
   output wordT qA,
   output wordT qB
);

   wordT mem [0:(1 << `MEM_ADDR_W)-1];

   // read before write on both ports
   always @(posedge clk)
   begin
      if (enA)
      begin
         qA <= mem[addrA];
         if (weA)
            mem[addrA] <= dataA;
      end
   end

   always @(posedge clk)
   begin
      if (enB)
      begin
         qB <= mem[addrB];
         if (weB)
            mem[addrB] <= dataB;
      end
   end

endmodule

`default_nettype wire

//--- hdl/affineAddrGen.sv
`timescale 1ns/1ps
`default_nettype none

`include "memUnit_cfg.svh"

module affineAddrGen
   import memUnitPkg::*;
(
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 run,
   input  addrT                 iter,
   input  logic [`PERIOD_W-1:0] per,
   input  logic [`PERIOD_W-1:0] duty,
   input  addrT                 start,
   input  addrT                 incr,
   input  addrT                 shift,
   input  logic [`PERIOD_W-1:0] delay,
   input  addrT                 iter2,
   input  addrT                 shift2,
   output addrT                 genAddr,
   output logic                 memEn,
   output logic                 done
);

   // zero counts behave as one
   logic [`PERIOD_W-1:0] perEff;
   addrT                 iterEff;
   addrT                 iter2Eff;

   logic                 launch;
   logic                 waiting;
   logic                 active;
   logic [`PERIOD_W-1:0] delayCnt;

   logic [`PERIOD_W-1:0] perCnt;
   addrT                 innerCnt;
   addrT                 outerCnt;
   logic                 lastK;
   logic                 lastJ;
   logic                 lastI;

   addrT                 curAddr;
   addrT                 innerBase;
   addrT                 outerBase;

   assign perEff   = (per == '0) ? `PERIOD_W'(1) : per;
   assign iterEff  = (iter == '0) ? addrT'(1) : iter;
   assign iter2Eff = (iter2 == '0) ? addrT'(1) : iter2;

   // runs while busy are dropped
   assign launch = run & done;

   assign lastK = (perCnt == perEff - 1'b1);
   assign lastJ = (innerCnt == iterEff - 1'b1);
   assign lastI = (outerCnt == iter2Eff - 1'b1);

   // phase control
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         done     <= 1'b1;
         waiting  <= 1'b0;
         active   <= 1'b0;
         delayCnt <= '0;
      end
      else if (launch)
      begin
         done     <= 1'b0;
         waiting  <= (delay != '0);
         active   <= (delay == '0);
         delayCnt <= delay - 1'b1;
      end
      else if (waiting)
      begin
         if (delayCnt == '0)
         begin
            waiting <= 1'b0;
            active  <= 1'b1;
         end
         else
         begin
            delayCnt <= delayCnt - 1'b1;
         end
      end
      else if (active & lastK & lastJ & lastI)
      begin
         active <= 1'b0;
         done   <= 1'b1;
      end
   end

   // loop counters with period innermost
   always_ff @(posedge clk)
   begin
      if (!rstN || launch)
      begin
         perCnt   <= '0;
         innerCnt <= '0;
         outerCnt <= '0;
      end
      else if (active)
      begin
         if (!lastK)
         begin
            perCnt <= perCnt + 1'b1;
         end
         else
         begin
            perCnt <= '0;
            if (!lastJ)
            begin
               innerCnt <= innerCnt + 1'b1;
            end
            else
            begin
               innerCnt <= '0;
               outerCnt <= outerCnt + 1'b1;
            end
         end
      end
   end

   // start + i*shift2 + j*shift + k*incr kept as running sums
   always_ff @(posedge clk)
   begin
      if (launch)
      begin
         curAddr   <= start;
         innerBase <= start;
         outerBase <= start;
      end
      else if (active)
      begin
         if (!lastK)
         begin
            curAddr <= curAddr + incr;
         end
         else if (!lastJ)
         begin
            innerBase <= innerBase + shift;
            curAddr   <= innerBase + shift;
         end
         else
         begin
            outerBase <= outerBase + shift2;
            innerBase <= outerBase + shift2;
            curAddr   <= outerBase + shift2;
         end
      end
   end

   assign genAddr = curAddr;
   assign memEn   = active & (perCnt < duty);

endmodule

`default_nettype wire

//--- hdl/memUnitPkg.sv
`default_nettype none

`include "memUnit_cfg.svh"

package memUnitPkg;

   typedef logic [`MEM_ADDR_W-1:0] addrT;

   typedef logic [`DATA_W-1:0] wordT;

   // one port's configuration word with the first field at the msb end
   typedef struct packed {
      addrT                 iter;
      logic [`PERIOD_W-1:0] per;
      logic [`PERIOD_W-1:0] duty;
      // flowIn word feeding this port
      logic [`N_W-1:0]      sel;
      addrT                 start;
      addrT                 incr;
      addrT                 shift;
      logic [`PERIOD_W-1:0] delay;
      logic                 reverse;
      // input word addresses the other port
      logic                 ext;
      logic                 inWr;
      // outer loop
      addrT                 iter2;
      addrT                 shift2;
   } memPortCfgT;

endpackage

`default_nettype wire

//--- include/memUnit_cfg.svh
`ifndef MEMUNIT_CFG_SVH
`define MEMUNIT_CFG_SVH

// ram address width and width of counts and strides
`define MEM_ADDR_W 10

// datapath word
`define DATA_W 32

// period, duty and start delay
`define PERIOD_W 5

// words on the datapath input bus
`define N_SOURCES 8

// source select width is log2 of N_SOURCES
`define N_W 3

`endif
